// File: verilog.f
+incdir+.
osf_pkg.sv
adc_sample_rx.sv
channel_config_regs.sv
oversample_filter.sv
result_sender.sv
osf_top.sv
osf_tb.sv

// File: Makefile
VERILATOR  := verilator
FLAGS      := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only -Wall --timing
TOP        := osf_tb
RTL_TOP    := osf_top
FILELIST   := verilog.f
OBJ_DIR    := obj_dir
LOG        := sim.log
SRCS       := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run lint clean

all: run

$(OBJ_DIR)/V$(TOP): $(SRCS) $(FILELIST) osf_config.svh
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(OBJ_DIR)/V$(TOP)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "RESULT: FAIL" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "RESULT: PASS" $(LOG) || (echo "simulation ended without a verdict"; exit 1)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: osf_tb.sv
`timescale 1ns/1ps
`include "osf_config.svh"

module osf_tb;
	import osf_pkg::*;

	localparam int ACK_TIMEOUT   = 50;		// cycles per handshake phase
	localparam int DRAIN_TIMEOUT = 2000;
	localparam int NUM_ROWS      = 7;

	typedef logic [`OSF_W_EP-1:0] ep_word_t;
	typedef enum int {C_IDLE, C_WAIT, C_ACKED} cons_state_t;

	// one stimulus row, chan 2 means both channels interleaved
	typedef struct packed {
		int         chan;
		int         osm;
		int         dly;
		int         n_samp;
		int         ack_dly;		// negative holds ack until the row is sent
		int         restart_at;		// sample index for off then on, 0 for none
		logic [1:0] exp_ovf;
	} row_t;

	localparam row_t ROWS [NUM_ROWS] = '{
		'{0, 0, 0,  6,  1, 0, 2'b00},		// every sample is a result
		'{1, 2, 0, 16,  2, 0, 2'b00},
		'{0, 5, 0, 64,  0, 0, 2'b00},
		'{1, 1, 3, 14,  1, 0, 2'b00},		// three skipped between averages
		'{0, 2, 1, 12,  1, 2, 2'b00},		// restart drops the partial sum
		'{2, 1, 1, 24,  2, 0, 2'b00},		// ch1 runs at osm+1
		'{0, 0, 0,  2, -1, 0, 2'b01}		// second result hits a full slot
	};

	logic                   clk_in = 1'b0;
	logic                   osf_reset;
	logic                   adc_req;
	chan_t                  adc_chan;
	sample_t                adc_data;
	logic                   adc_ack;
	logic                   cfg_wr_en;
	chan_t                  cfg_chan;
	cfg_field_t             cfg_field;
	ep_word_t               cfg_data;
	logic                   out_req;
	chan_t                  out_chan;
	sample_t                out_data;
	logic                   out_ack;
	logic [`OSF_N_CHAN-1:0] overflow;

	////////////////////////////////////////////////////////////
	// reference model state, one entry per channel
	////////////////////////////////////////////////////////////

	logic [31:0] rng_state = 32'h2566;
	bit          m_active [2];
	int          m_osm [2];
	int          m_dly [2];
	int          m_skip [2];		// samples still to discard
	int          m_n [2];
	longint      m_acc [2];
	bit          slot_taken [2];	// only tracked while ack is held
	int          exp_q0 [$];
	int          exp_q1 [$];
	int          ack_dly_cur;
	bit          hold_ack;
	cons_state_t cons_state;

	osf_top osf_top_inst (
		.clk_in, .osf_reset,
		.adc_req, .adc_chan, .adc_data, .adc_ack,
		.cfg_wr_en, .cfg_chan, .cfg_field, .cfg_data,
		.out_req, .out_chan, .out_data, .out_ack,
		.overflow
	);

	always #4 clk_in = ~clk_in;		// 8 ns period

	task automatic fail_run(input string msg);
		$display("%s", msg);
		$display("RESULT: FAIL");
		$fatal(1, "stopped at first failure");
	endtask

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// floor of acc / 2^osm, rounds toward minus infinity
	function automatic int floor_mean(input longint acc, input int osm);
		longint div;
		longint q;
		div = longint'(1) << osm;
		q   = acc / div;
		if (acc < 0 && q * div != acc)
			q = q - 1;
		return int'(q);
	endfunction

	function automatic int exp_count(input int ch);
		return (ch == 0) ? exp_q0.size() : exp_q1.size();
	endfunction

	function automatic int pop_expected(input int ch);
		if (ch == 0)
			return exp_q0.pop_front();
		return exp_q1.pop_front();
	endfunction

	// with ack held the slot keeps its first result, later ones are lost
	task automatic push_expected(input int ch, input int mean);
		if (hold_ack && slot_taken[ch])
			return;
		if (hold_ack)
			slot_taken[ch] = 1'b1;
		if (ch == 0)
			exp_q0.push_back(mean);
		else
			exp_q1.push_back(mean);
	endtask

	task automatic model_sample(input int ch, input int value);
		if (!m_active[ch])
			return;						// channel off, word ignored
		if (m_skip[ch] > 0) begin
			m_skip[ch]--;				// settling
			return;
		end
		m_acc[ch] += value;
		m_n[ch]++;
		if (m_n[ch] == (1 << m_osm[ch])) begin
			push_expected(ch, floor_mean(m_acc[ch], m_osm[ch]));
			m_acc[ch]  = 0;
			m_n[ch]    = 0;
			m_skip[ch] = m_dly[ch];
		end
	endtask

	task automatic idle(input int n);
		repeat (n) @(posedge clk_in);
		#1;
	endtask

	////////////////////////////////////////////////////////////
	// front panel writes and adc handshake
	////////////////////////////////////////////////////////////

	task automatic write_cfg(input int ch, input cfg_field_t field, input int value);
		cfg_chan  = chan_t'(ch);
		cfg_field = field;
		cfg_data  = ep_word_t'(value);
		cfg_wr_en = 1'b1;
		idle(1);
		cfg_wr_en = 1'b0;
	endtask

	task automatic deactivate(input int ch);
		write_cfg(ch, CFG_ACTIVATE, 0);
		m_active[ch] = 1'b0;
	endtask

	// first average after activation starts with no delay
	task automatic activate_channel(input int ch);
		write_cfg(ch, CFG_ACTIVATE, 1);
		m_active[ch] = 1'b1;
		m_acc[ch]    = 0;
		m_n[ch]      = 0;
		m_skip[ch]   = 0;
	endtask

	task automatic set_channel(input int ch, input int osm, input int dly);
		write_cfg(ch, CFG_OSM, osm);
		write_cfg(ch, CFG_DELAY, dly);
		m_osm[ch] = osm;
		m_dly[ch] = dly;
		activate_channel(ch);
	endtask

	task automatic send_sample(input int ch, input int value);
		int t;
		adc_chan = chan_t'(ch);
		adc_data = sample_t'(value);
		adc_req  = 1'b1;
		t = 0;
		while (!adc_ack) begin
			idle(1);
			t++;
			assert (t < ACK_TIMEOUT) else
				fail_run("timed out waiting for adc_ack to rise");
		end
		adc_req = 1'b0;
		t = 0;
		while (adc_ack) begin
			idle(1);
			t++;
			assert (t < ACK_TIMEOUT) else
				fail_run("timed out waiting for adc_ack to fall");
		end
	endtask

	task automatic wait_drain();
		int t;
		t = 0;
		idle(6);		// let a stray result show up
		while (exp_count(0) != 0 || exp_count(1) != 0 || cons_state != C_IDLE || out_req) begin
			idle(1);
			t++;
			assert (t < DRAIN_TIMEOUT) else
				fail_run("timed out waiting for the expected results to come out");
		end
	endtask

	task automatic check_output();
		int ch;
		int want;
		ch = int'(out_chan);
		assert (exp_count(ch) > 0) else
			fail_run($sformatf("ERROR: %0t: unexpected result %0d on channel %0d",
				$time, out_data, ch));
		want = pop_expected(ch);
		assert (int'(out_data) == want) else
			fail_run($sformatf("ERROR: %0t: channel %0d result %0d expected %0d",
				$time, ch, out_data, want));
	endtask

	task automatic apply_row(input row_t r);
		int      i;
		int      ch;
		sample_t s;
		deactivate(0);
		deactivate(1);
		if (r.chan == 2) begin
			set_channel(0, r.osm, r.dly);
			set_channel(1, r.osm + 1, r.dly);
		end else begin
			set_channel(r.chan, r.osm, r.dly);
		end
		idle(2);
		hold_ack      = (r.ack_dly < 0);
		ack_dly_cur   = (r.ack_dly < 0) ? 0 : r.ack_dly;
		slot_taken[0] = 1'b0;
		slot_taken[1] = 1'b0;
		for (i = 0; i < r.n_samp; i++) begin
			ch = (r.chan == 2) ? i % 2 : r.chan;
			if (r.restart_at != 0 && i == r.restart_at) begin
				deactivate(ch);			// partial sum thrown away
				idle(2);
				activate_channel(ch);
			end
			rng_state = xorshift32(rng_state);
			s = rng_state[`OSF_W_DATA-1:0];
			model_sample(ch, int'(s));	// expected first, output may be quick
			send_sample(ch, int'(s));
		end
		if (hold_ack) begin
			idle(4);					// drop lands before release
			hold_ack = 1'b0;
		end
		wait_drain();
		assert (overflow == r.exp_ovf) else
			fail_run($sformatf("ERROR: %0t: overflow %b expected %b",
				$time, overflow, r.exp_ovf));
	endtask

	////////////////////////////////////////////////////////////
	// consumer side of the output handshake
	////////////////////////////////////////////////////////////

	initial begin
		int ack_count;
		out_ack    = 1'b0;
		cons_state = C_IDLE;
		ack_count  = 0;
		forever begin
			@(posedge clk_in);
			#1;
			case (cons_state)
				C_IDLE: if (out_req) begin
					check_output();
					ack_count  = ack_dly_cur;
					cons_state = C_WAIT;
				end
				C_WAIT: if (!hold_ack) begin
					if (ack_count <= 0) begin
						out_ack    = 1'b1;
						cons_state = C_ACKED;
					end else begin
						ack_count--;
					end
				end
				C_ACKED: if (!out_req) begin
					out_ack    = 1'b0;
					cons_state = C_IDLE;
				end
				default: cons_state = C_IDLE;
			endcase
		end
	end

	initial begin
		int i;
		osf_reset   = 1'b1;
		adc_req     = 1'b0;
		adc_chan    = '0;
		adc_data    = '0;
		cfg_wr_en   = 1'b0;
		cfg_chan    = '0;
		cfg_field   = CFG_DELAY;
		cfg_data    = '0;
		hold_ack    = 1'b0;
		ack_dly_cur = 0;
		for (i = 0; i < 2; i++)
			m_active[i] = 1'b0;
		repeat (3) @(posedge clk_in);
		#1;
		osf_reset = 1'b0;
		idle(1);
		assert (!out_req && overflow == '0) else
			fail_run($sformatf("ERROR: %0t: out_req or overflow high after reset", $time));
		// both channels still off, words must vanish
		for (i = 0; i < 4; i++) begin
			rng_state = xorshift32(rng_state);
			model_sample(i % 2, int'(sample_t'(rng_state[`OSF_W_DATA-1:0])));
			send_sample(i % 2, int'(sample_t'(rng_state[`OSF_W_DATA-1:0])));
		end
		idle(10);
		assert (!out_req) else
			fail_run($sformatf("ERROR: %0t: out_req high with channels off", $time));
		for (i = 0; i < NUM_ROWS; i++)
			apply_row(ROWS[i]);
		$display("RESULT: PASS");
		$finish;
	end

endmodule

// File: osf_top.sv
`timescale 1ns/1ps
`include "osf_config.svh"

module osf_top (
	input  logic                    clk_in,
	input  logic                    osf_reset,
	// converter side
	input  logic                    adc_req,
	input  osf_pkg::chan_t          adc_chan,
	input  osf_pkg::sample_t        adc_data,
	output logic                    adc_ack,
	// front panel writes
	input  logic                    cfg_wr_en,
	input  osf_pkg::chan_t          cfg_chan,
	input  osf_pkg::cfg_field_t     cfg_field,
	input  logic [`OSF_W_EP-1:0]    cfg_data,
	// consumer side
	output logic                    out_req,
	output osf_pkg::chan_t          out_chan,
	output osf_pkg::sample_t        out_data,
	input  logic                    out_ack,
	output logic [`OSF_N_CHAN-1:0]  overflow
);
	import osf_pkg::*;

	sample_t                         sample_data;
	logic [`OSF_N_CHAN-1:0]          sample_valid;
	delay_t [`OSF_N_CHAN-1:0]        cycle_delay;
	osm_t [`OSF_N_CHAN-1:0]          osm;
	logic [`OSF_N_CHAN-1:0]          activate;
	sample_t [`OSF_N_CHAN-1:0]       filt_data;
	logic [`OSF_N_CHAN-1:0]          filt_valid;

	adc_sample_rx adc_sample_rx_inst (
		.clk_in, .osf_reset,
		.adc_req, .adc_chan, .adc_data, .adc_ack,
		.sample_data, .sample_valid
	);

	channel_config_regs channel_config_regs_inst (
		.clk_in, .osf_reset,
		.cfg_wr_en, .cfg_chan, .cfg_field, .cfg_data,
		.cycle_delay, .osm, .activate
	);

	// one filter per channel, all share the captured word
	for (genvar i = 0; i < `OSF_N_CHAN; i++) begin : g_filt
		oversample_filter oversample_filter_inst (
			.clk_in         (clk_in),
			.osf_reset      (osf_reset),
			.data_in        (sample_data),
			.data_valid_in  (sample_valid[i]),
			.cycle_delay_in (cycle_delay[i]),
			.osm_in         (osm[i]),
			.activate_in    (activate[i]),
			.data_out       (filt_data[i]),
			.data_valid_out (filt_valid[i])
		);
	end

	result_sender result_sender_inst (
		.clk_in, .osf_reset,
		.filt_data, .filt_valid,
		.out_req, .out_chan, .out_data, .out_ack,
		.overflow
	);

endmodule

// File: result_sender.sv
`timescale 1ns/1ps
`include "osf_config.svh"

module result_sender (
	input  logic                                clk_in,
	input  logic                                osf_reset,
	input  osf_pkg::sample_t [`OSF_N_CHAN-1:0]  filt_data,
	input  logic [`OSF_N_CHAN-1:0]              filt_valid,
	output logic                                out_req,
	output osf_pkg::chan_t                      out_chan,	// doubles as last served channel
	output osf_pkg::sample_t                    out_data,
	input  logic                                out_ack,
	output logic [`OSF_N_CHAN-1:0]              overflow	// sticky until reset
);
	import osf_pkg::*;

	typedef enum logic [1:0] {
		S_IDLE,
		S_REQ,			// req high, wait for ack
		S_RELEASE		// req low, wait for ack to drop
	} send_state_t;

	send_state_t state;

	logic [`OSF_N_CHAN-1:0] slot_full;
	sample_t                slot_data [`OSF_N_CHAN];
	logic [`OSF_N_CHAN-1:0] slot_free;		// handshake done this cycle
	logic [`OSF_N_CHAN-1:0] slot_load;
	logic                   grant_any;
	chan_t                  grant_chan;

	////////////////////////////////////////////////////////////
	// holding slots
	////////////////////////////////////////////////////////////

	always_comb begin
		slot_free = '0;
		if (state == S_RELEASE && !out_ack)
			slot_free[out_chan] = 1'b1;
		slot_load = filt_valid & (~slot_full | slot_free);	// freeing slot takes the new word
	end

	always_ff @(posedge clk_in) begin
		if (osf_reset) begin
			slot_full <= '0;
			overflow  <= '0;
		end else begin
			slot_full <= (slot_full & ~slot_free) | slot_load;
			overflow  <= overflow | (filt_valid & ~slot_load);	// dropped result
		end
	end

	always_ff @(posedge clk_in) begin
		for (int i = 0; i < `OSF_N_CHAN; i++)
			if (slot_load[i])
				slot_data[i] <= filt_data[i];
	end

	// round robin, search starts after the channel served last
	always_comb begin
		int idx;
		grant_any  = 1'b0;
		grant_chan = out_chan;
		for (int k = `OSF_N_CHAN; k >= 1; k--) begin
			idx = (int'(out_chan) + k) % `OSF_N_CHAN;
			if (slot_full[idx]) begin
				grant_any  = 1'b1;
				grant_chan = chan_t'(idx);		// nearest wins, loop runs far to near
			end
		end
	end

	////////////////////////////////////////////////////////////
	// four phase output
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk_in) begin
		if (osf_reset) begin
			state    <= S_IDLE;
			out_req  <= 1'b0;
			out_chan <= '0;
		end else begin
			case (state)
				S_IDLE: if (grant_any) begin
					out_req  <= 1'b1;
					out_chan <= grant_chan;
					state    <= S_REQ;
				end
				S_REQ: if (out_ack) begin
					out_req <= 1'b0;
					state   <= S_RELEASE;
				end
				S_RELEASE: if (!out_ack)
					state <= S_IDLE;			// slot freed on this edge
				default: state <= S_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk_in) begin
		if (state == S_IDLE && grant_any)
			out_data <= slot_data[grant_chan];
	end

	a_out_stable: assert property (@(posedge clk_in) disable iff (osf_reset)
		out_req |=> !out_req || ($stable(out_chan) && $stable(out_data)));

endmodule

// File: oversample_filter.sv
`timescale 1ns/1ps
`include "osf_config.svh"

module oversample_filter (
	input  logic               clk_in,
	input  logic               osf_reset,
	input  osf_pkg::sample_t   data_in,
	input  logic               data_valid_in,	// one cycle per adc word
	input  osf_pkg::delay_t    cycle_delay_in,	// samples to skip between averages
	input  osf_pkg::osm_t      osm_in,			// log2 of oversample ratio
	input  logic               activate_in,
	output osf_pkg::sample_t   data_out,
	output logic               data_valid_out
);
	import osf_pkg::*;

	////////////////////////////////////////////////////////////
	// sizing and state encoding
	////////////////////////////////////////////////////////////

	localparam int MAX_OS = 2**`OSF_W_OSM - 1;			// largest log2 ratio
	localparam int W_SUM  = MAX_OS + $bits(sample_t);	// 33 bits, no overflow at max ratio

	typedef enum logic [1:0] {
		ST_IDLE,		// waiting for activate
		ST_DELAY,		// skip samples while dac/dds settles
		ST_SAMPLE,		// accumulate
		ST_SEND			// result valid for one cycle
	} state_t;

	state_t cur_state;
	state_t next_state;

	logic                    ch_reset;			// system reset or channel off
	logic [MAX_OS:0]         sample_counter;	// words seen in current state
	logic signed [W_SUM-1:0] sum;
	logic signed [W_SUM-1:0] sum_shift;

	assign ch_reset = osf_reset | ~activate_in;

	// mean is the sum shifted down by osm, arithmetic so negatives floor
	assign sum_shift      = sum >>> osm_in;
	assign data_out       = sum_shift[$bits(sample_t)-1:0];
	assign data_valid_out = (cur_state == ST_SEND);

	////////////////////////////////////////////////////////////
	// accumulator and sample count
	////////////////////////////////////////////////////////////

	// cleared every pass through idle and delay
	always_ff @(posedge clk_in) begin
		if (cur_state == ST_IDLE || cur_state == ST_DELAY)
			sum <= '0;
		else if (cur_state == ST_SAMPLE && data_valid_in)
			sum <= sum + W_SUM'(data_in);		// sign extended add
	end

	always_ff @(posedge clk_in) begin
		if (ch_reset)
			sample_counter <= '0;
		else if (cur_state != next_state)
			sample_counter <= '0;				// restart count on every transition
		else if (data_valid_in)
			sample_counter <= sample_counter + 1'b1;
	end

	////////////////////////////////////////////////////////////
	// state machine
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk_in) begin
		if (ch_reset)
			cur_state <= ST_IDLE;
		else
			cur_state <= next_state;
	end

	always_comb begin
		next_state = cur_state;
		case (cur_state)
			ST_IDLE: begin
				if (activate_in)
					next_state = ST_SAMPLE;		// first average skips the delay
			end
			ST_DELAY: begin
				if (sample_counter >= cycle_delay_in)
					next_state = ST_SAMPLE;
			end
			ST_SAMPLE: begin
				if (sample_counter[osm_in])		// 2^osm words in
					next_state = ST_SEND;
			end
			ST_SEND:
				next_state = ST_DELAY;
			default:
				next_state = ST_IDLE;
		endcase
	end

	// a back to back pulse would be added while leaving sample
	a_valid_spacing: assert property (@(posedge clk_in) disable iff (osf_reset)
		data_valid_in |=> !data_valid_in);

endmodule

// File: channel_config_regs.sv
`timescale 1ns/1ps
`include "osf_config.svh"

module channel_config_regs (
	input  logic                                   clk_in,
	input  logic                                   osf_reset,
	input  logic                                   cfg_wr_en,		// front panel write strobe
	input  osf_pkg::chan_t                         cfg_chan,
	input  osf_pkg::cfg_field_t                    cfg_field,
	input  logic [`OSF_W_EP-1:0]                   cfg_data,
	output osf_pkg::delay_t [`OSF_N_CHAN-1:0]      cycle_delay,
	output osf_pkg::osm_t [`OSF_N_CHAN-1:0]        osm,
	output logic [`OSF_N_CHAN-1:0]                 activate
);
	import osf_pkg::*;

	logic [`OSF_N_CHAN-1:0] chan_sel;		// decoded write target

	always_comb begin
		for (int i = 0; i < `OSF_N_CHAN; i++)
			chan_sel[i] = cfg_wr_en && (cfg_chan == chan_t'(i));
	end

	////////////////////////////////////////////////////////////
	// per channel settings
	////////////////////////////////////////////////////////////

	// everything clears on reset, channels come up deactivated
	always_ff @(posedge clk_in) begin
		if (osf_reset) begin
			cycle_delay <= '0;
			osm         <= '0;
			activate    <= '0;
		end else begin
			for (int i = 0; i < `OSF_N_CHAN; i++) begin
				if (chan_sel[i]) begin
					case (cfg_field)
						CFG_DELAY:    cycle_delay[i] <= cfg_data;
						CFG_OSM:      osm[i] <= cfg_data[`OSF_W_OSM-1:0];	// low bits only
						CFG_ACTIVATE: activate[i] <= cfg_data[0];
						default:      ;		// unused field code, ignore
					endcase
				end
			end
		end
	end

endmodule

// File: adc_sample_rx.sv
`timescale 1ns/1ps
`include "osf_config.svh"

module adc_sample_rx (
	input  logic                    clk_in,
	input  logic                    osf_reset,
	input  logic                    adc_req,		// async from converter
	input  osf_pkg::chan_t          adc_chan,
	input  osf_pkg::sample_t        adc_data,
	output logic                    adc_ack,
	output osf_pkg::sample_t        sample_data,
	output logic [`OSF_N_CHAN-1:0]  sample_valid	// one-hot, single cycle
);
	import osf_pkg::*;

	logic req_s1;		// first sync stage
	logic req_s2;		// synchronized req
	logic capture;

	// new word when req seen high and not yet acked
	assign capture = req_s2 & ~adc_ack;

	////////////////////////////////////////////////////////////
	// req sync and ack side of the four phase cycle
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk_in) begin
		if (osf_reset) begin
			req_s1       <= 1'b0;
			req_s2       <= 1'b0;
			adc_ack      <= 1'b0;
			sample_valid <= '0;
		end else begin
			req_s1 <= adc_req;
			req_s2 <= req_s1;
			if (capture)
				adc_ack <= 1'b1;		// rises with the valid pulse
			else if (!req_s2)
				adc_ack <= 1'b0;		// release once req dropped
			for (int i = 0; i < `OSF_N_CHAN; i++)
				sample_valid[i] <= capture && (adc_chan == chan_t'(i));
		end
	end

	// data is stable while req high so no sync needed
	always_ff @(posedge clk_in) begin
		if (capture)
			sample_data <= adc_data;
	end

	// converter must wait for ack to drop before a new req
	a_req_after_ack: assert property (@(posedge clk_in) disable iff (osf_reset)
		$rose(req_s2) |-> !adc_ack);

endmodule

// File: osf_pkg.sv
`include "osf_config.svh"

package osf_pkg;

	////////////////////////////////////////////////////////////
	// payload and register field types
	////////////////////////////////////////////////////////////

	typedef logic signed [`OSF_W_DATA-1:0] sample_t;		// one adc word
	typedef logic [`OSF_W_EP-1:0] delay_t;					// settling delay in adc samples
	typedef logic [`OSF_W_OSM-1:0] osm_t;					// log2 of oversample ratio
	typedef logic [$clog2(`OSF_N_CHAN)-1:0] chan_t;			// channel tag

	// front panel register select
	typedef enum logic [1:0] {
		CFG_DELAY    = 2'd0,
		CFG_OSM      = 2'd1,
		CFG_ACTIVATE = 2'd2
	} cfg_field_t;

endpackage

// File: osf_config.svh
`ifndef OSF_CONFIG_SVH
`define OSF_CONFIG_SVH

////////////////////////////////////////////////////////////
// oversample front end sizing
////////////////////////////////////////////////////////////

// adc word width, signed two's complement
`define OSF_W_DATA 18

// front panel endpoint word, also the delay register width
`define OSF_W_EP 16

// oversample mode width
// max ratio is 2^(2^W_OSM - 1) = 2^15
`define OSF_W_OSM 4

// number of filter channels
`define OSF_N_CHAN 2

`endif
